// File: verilog.f
+incdir+common
common/cache_pkg.sv
cache_line/cache_line.sv
hw/victim_select.sv
hw/miss_control.sv
hw/hybrid_cache.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/tb_hybrid_cache.sv

// File: Bender.yml
package:
  name: hybrid_cache

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - cache_line/cache_line.sv
      - hw/victim_select.sv
      - hw/miss_control.sv
      - hw/hybrid_cache.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/clock_gen.sv
      - tests/mem_model.sv
      - tests/tb_hybrid_cache.sv

// File: tests/tb_hybrid_cache.sv
`include "cache_config.svh"
`default_nettype none

module tb_hybrid_cache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = 4000;
	localparam int NUM_LINES = `CACHE_NUM_LINES;
	localparam int BLOCK_WORDS = `CACHE_LINE_WORDS;

	wire clk;
	wire reset_n;

	cache_pkg::addr_t dcache_rdaddr;
	logic dcache_rdreq;
	cache_pkg::data_t dcache_out;
	logic dcache_out_valid;
	logic dcache_rd_ready;
	cache_pkg::addr_t dcache_wraddr;
	logic dcache_wrreq;
	cache_pkg::data_t dcache_in;
	logic dcache_wr_ready;
	cache_pkg::addr_t icache_rdaddr;
	logic icache_rdreq;
	cache_pkg::data_t icache_out;
	logic icache_out_valid;
	logic icache_rd_ready;
	cache_pkg::addr_t mem_addr;
	cache_pkg::data_t mem_in;
	cache_pkg::data_t mem_out;
	logic mem_out_valid;
	logic mem_wrreq;
	logic mem_rdreq;

	int cycles = 0;
	int mem_reads = 0;
	int mem_writes = 0;
	int exp_reads = 0;
	int exp_writes = 0;
	logic [31:0] rng_state = 32'h40b6407f;
	cache_pkg::data_t written [logic [31:0]];
	cache_pkg::tag_t model_tag [NUM_LINES];
	logic model_valid [NUM_LINES] = '{default: 1'b0};
	logic model_dirty [NUM_LINES] = '{default: 1'b0};
	int model_cnt [NUM_LINES] = '{default: 0};
	cache_pkg::tag_t lost_tag;

	clock_gen u_clock_gen (
		.clk(clk),
		.reset_n(reset_n)
	);

	mem_model u_mem_model (
		.clk(clk),
		.reset_n(reset_n),
		.mem_addr(mem_addr),
		.mem_in(mem_in),
		.mem_wrreq(mem_wrreq),
		.mem_rdreq(mem_rdreq),
		.mem_out(mem_out),
		.mem_out_valid(mem_out_valid)
	);

	hybrid_cache u_hybrid_cache (
		.clk(clk),
		.reset_n(reset_n),
		.dcache_rdaddr(dcache_rdaddr),
		.dcache_rdreq(dcache_rdreq),
		.dcache_out(dcache_out),
		.dcache_out_valid(dcache_out_valid),
		.dcache_rd_ready(dcache_rd_ready),
		.dcache_wraddr(dcache_wraddr),
		.dcache_wrreq(dcache_wrreq),
		.dcache_in(dcache_in),
		.dcache_wr_ready(dcache_wr_ready),
		.icache_rdaddr(icache_rdaddr),
		.icache_rdreq(icache_rdreq),
		.icache_out(icache_out),
		.icache_out_valid(icache_out_valid),
		.icache_rd_ready(icache_rd_ready),
		.mem_addr(mem_addr),
		.mem_in(mem_in),
		.mem_out(mem_out),
		.mem_out_valid(mem_out_valid),
		.mem_wrreq(mem_wrreq),
		.mem_rdreq(mem_rdreq)
	);

	always @(posedge clk) begin
		if (mem_rdreq)
			mem_reads <= mem_reads + 1;
		if (mem_wrreq)
			mem_writes <= mem_writes + 1;
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$fatal(1, "cycle limit reached");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic cache_pkg::data_t next_random();
		rng_state = xorshift32(rng_state);
		return cache_pkg::data_t'(rng_state);
	endfunction

	function automatic cache_pkg::data_t expected_word(input cache_pkg::addr_t addr);
		if (written.exists(addr.raw))
			return written[addr.raw];
		return cache_pkg::data_t'(xorshift32(addr.raw));
	endfunction

	function automatic cache_pkg::addr_t block_addr(input int block, input int word);
		cache_pkg::addr_t addr;
		addr.fields.tag = cache_pkg::tag_t'(32'h4000 + block);
		addr.fields.word_idx = cache_pkg::word_idx_t'(word);
		addr.fields.byte_off = '0;
		return addr;
	endfunction

	// the lowest hit count is evicted first and the lowest index breaks a tie
	function automatic void model_access(input cache_pkg::tag_t tag, input logic is_write);
		int idx;
		int i;
		idx = -1;
		for (i = 0; i < NUM_LINES; i++) begin
			if (model_valid[i] && model_tag[i] == tag)
				idx = i;
		end
		if (idx < 0) begin
			idx = 0;
			for (i = 1; i < NUM_LINES; i++) begin
				if (model_cnt[i] < model_cnt[idx])
					idx = i;
			end
			if (model_valid[idx])
				lost_tag = model_tag[idx];
			if (model_dirty[idx])
				exp_writes += BLOCK_WORDS;
			exp_reads += BLOCK_WORDS;
			model_tag[idx] = tag;
			model_valid[idx] = 1'b1;
			model_dirty[idx] = 1'b0;
			model_cnt[idx] = 0;
		end
		if (is_write)
			model_dirty[idx] = 1'b1;
		if (model_cnt[idx] < (1 << `CACHE_HIT_BITS) - 1)
			model_cnt[idx]++;
	endfunction

	task automatic check_data(input string name, input cache_pkg::data_t expected,
		input cache_pkg::data_t actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "data check failed");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "flag check failed");
		end
	endtask

	// memory traffic so far must match what the model expects
	task automatic note_access(input string name, input cache_pkg::addr_t addr,
		input logic is_write);
		model_access(addr.fields.tag, is_write);
		check_data({name, " memory reads"}, cache_pkg::data_t'(exp_reads),
			cache_pkg::data_t'(mem_reads));
		check_data({name, " memory writes"}, cache_pkg::data_t'(exp_writes),
			cache_pkg::data_t'(mem_writes));
	endtask

	task automatic read_data_port(input cache_pkg::addr_t addr, output cache_pkg::data_t data);
		@(posedge clk);
		dcache_rdaddr <= addr;
		dcache_rdreq <= 1'b1;
		do @(negedge clk); while (!dcache_rd_ready);
		@(posedge clk);
		dcache_rdreq <= 1'b0;
		@(negedge clk);
		check_flag("data read valid", 1'b1, dcache_out_valid);
		data = dcache_out;
	endtask

	task automatic read_inst_port(input cache_pkg::addr_t addr, output cache_pkg::data_t data);
		@(posedge clk);
		icache_rdaddr <= addr;
		icache_rdreq <= 1'b1;
		do @(negedge clk); while (!icache_rd_ready);
		@(posedge clk);
		icache_rdreq <= 1'b0;
		@(negedge clk);
		check_flag("instruction read valid", 1'b1, icache_out_valid);
		data = icache_out;
	endtask

	task automatic write_data_port(input cache_pkg::addr_t addr, input cache_pkg::data_t data);
		@(posedge clk);
		dcache_wraddr <= addr;
		dcache_in <= data;
		dcache_wrreq <= 1'b1;
		do @(negedge clk); while (!dcache_wr_ready);
		@(posedge clk);
		dcache_wrreq <= 1'b0;
		@(negedge clk);
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_flag("reset state", 1'b0, dcache_out_valid);
		check_flag("reset state", 1'b0, icache_out_valid);
		check_flag("reset state", 1'b0, mem_rdreq);
		check_flag("reset state", 1'b0, mem_wrreq);
	endtask

	task automatic test_block_reads();
		cache_pkg::addr_t addr;
		cache_pkg::data_t data;
		int w;
		for (w = 0; w < BLOCK_WORDS; w++) begin
			addr = block_addr(0, w);
			read_data_port(addr, data);
			check_data("block read", expected_word(addr), data);
			note_access("block read", addr, 1'b0);
		end
	endtask

	task automatic test_unified_write();
		cache_pkg::addr_t addr;
		cache_pkg::data_t data;
		cache_pkg::data_t wdata;
		addr = block_addr(1, 1);
		wdata = next_random();
		write_data_port(addr, wdata);
		written[addr.raw] = wdata;
		note_access("unified write", addr, 1'b1);
		read_data_port(addr, data);
		check_data("write then data read", wdata, data);
		note_access("write then data read", addr, 1'b0);
		read_inst_port(addr, data);
		check_data("write then instruction read", wdata, data);
		note_access("write then instruction read", addr, 1'b0);
	endtask

	task automatic test_eviction();
		cache_pkg::addr_t addr;
		cache_pkg::data_t data;
		int blk;
		int rep;
		// seven new blocks join the two already cached, so one block must go
		for (blk = 2; blk < 9; blk++) begin
			for (rep = 0; rep < 3; rep++) begin
				addr = block_addr(blk, rep);
				read_data_port(addr, data);
				check_data("eviction fill", expected_word(addr), data);
				note_access("eviction fill", addr, 1'b0);
			end
		end
		addr.fields.tag = lost_tag;
		addr.fields.word_idx = 2'd1;
		addr.fields.byte_off = 2'd0;
		for (rep = 0; rep < 2; rep++) begin
			read_data_port(addr, data);
			check_data("evicted block reread", expected_word(addr), data);
			note_access("evicted block reread", addr, 1'b0);
		end
	endtask

	task automatic test_dual_read();
		cache_pkg::addr_t d_addr;
		cache_pkg::addr_t i_addr;
		cache_pkg::data_t d_data;
		cache_pkg::data_t i_data;
		int reads_before;
		d_addr = block_addr(9, 2);
		i_addr = block_addr(10, 3);
		reads_before = mem_reads;
		fork
			read_data_port(d_addr, d_data);
			read_inst_port(i_addr, i_data);
		join
		check_data("dual data read", expected_word(d_addr), d_data);
		check_data("dual instruction read", expected_word(i_addr), i_data);
		check_data("dual read memory reads", cache_pkg::data_t'(reads_before + 2 * BLOCK_WORDS),
			cache_pkg::data_t'(mem_reads));
	endtask

	initial begin
		dcache_rdaddr = '0;
		dcache_rdreq = 1'b0;
		dcache_wraddr = '0;
		dcache_wrreq = 1'b0;
		dcache_in = '0;
		icache_rdaddr = '0;
		icache_rdreq = 1'b0;
		wait (reset_n === 1'b1);
		@(posedge clk);
		test_reset_state();
		test_block_reads();
		test_unified_write();
		test_eviction();
		test_dual_read();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/mem_model.sv
`include "cache_config.svh"
`default_nettype none

module mem_model (
	input wire clk,
	input wire reset_n,
	input wire cache_pkg::addr_t mem_addr,
	input wire cache_pkg::data_t mem_in,
	input wire mem_wrreq,
	input wire mem_rdreq,
	output cache_pkg::data_t mem_out,
	output logic mem_out_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	cache_pkg::data_t store [logic [`CACHE_ADDR_BITS-1:0]];
	logic [31:0] lat_state;
	logic [2:0] wait_cnt;
	logic pending;
	cache_pkg::addr_t rd_addr;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// a word that was never written reads back a pattern of its own address
	function automatic cache_pkg::data_t word_at(input cache_pkg::addr_t addr);
		if (store.exists(addr.raw))
			return store[addr.raw];
		return cache_pkg::data_t'(xorshift32(addr.raw));
	endfunction

	always @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mem_out_valid <= 1'b0;
			mem_out <= '0;
			pending <= 1'b0;
			wait_cnt <= '0;
			rd_addr <= '0;
			lat_state <= 32'h40b6407f;
		end else begin
			mem_out_valid <= 1'b0;
			if (mem_wrreq)
				store[mem_addr.raw] = mem_in;
			if (pending) begin
				if (wait_cnt == 3'd1) begin
					pending <= 1'b0;
					mem_out_valid <= 1'b1;
					mem_out <= word_at(rd_addr);
				end else begin
					wait_cnt <= wait_cnt - 3'd1;
				end
			end
			// read latency of one to four cycles
			if (mem_rdreq) begin
				pending <= 1'b1;
				rd_addr <= mem_addr;
				wait_cnt <= {1'b0, lat_state[1:0]} + 3'd1;
				lat_state <= xorshift32(lat_state);
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/clock_gen.sv
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/hybrid_cache.sv
`include "cache_config.svh"
`default_nettype none

module hybrid_cache (
	input wire clk,
	input wire reset_n,

	input wire cache_pkg::addr_t dcache_rdaddr,
	input wire dcache_rdreq,
	output cache_pkg::data_t dcache_out,
	output logic dcache_out_valid,
	output logic dcache_rd_ready,

	input wire cache_pkg::addr_t dcache_wraddr,
	input wire dcache_wrreq,
	input wire cache_pkg::data_t dcache_in,
	output logic dcache_wr_ready,

	input wire cache_pkg::addr_t icache_rdaddr,
	input wire icache_rdreq,
	output cache_pkg::data_t icache_out,
	output logic icache_out_valid,
	output logic icache_rd_ready,

	output cache_pkg::addr_t mem_addr,
	output cache_pkg::data_t mem_in,
	input wire cache_pkg::data_t mem_out,
	input wire mem_out_valid,
	output logic mem_wrreq,
	output logic mem_rdreq
);

	wire cache_pkg::line_mask_t d_rd_hit;
	wire cache_pkg::line_mask_t d_wr_hit;
	wire cache_pkg::line_mask_t i_rd_hit;
	wire cache_pkg::line_mask_t line_busy;
	wire cache_pkg::line_mask_t line_wrreq;
	wire cache_pkg::line_mask_t line_rdreq;
	wire cache_pkg::data_t d_rd_data [`CACHE_NUM_LINES];
	wire cache_pkg::data_t i_rd_data [`CACHE_NUM_LINES];
	wire cache_pkg::hitcnt_t hitcnts [`CACHE_NUM_LINES];
	wire cache_pkg::addr_t line_mem_addr [`CACHE_NUM_LINES];
	wire cache_pkg::data_t line_mem_data [`CACHE_NUM_LINES];

	wire cache_pkg::line_mask_t victim;
	wire cache_pkg::line_mask_t fill;
	wire cache_pkg::tag_t fill_tag;
	wire refilling;

	logic d_rd_any_hit;
	logic d_wr_any_hit;
	logic i_rd_any_hit;
	logic d_rd_en;
	logic d_wr_en;
	logic i_rd_en;
	cache_pkg::data_t d_rd_mux;
	cache_pkg::data_t i_rd_mux;
	cache_pkg::addr_t mem_addr_mux;
	cache_pkg::data_t mem_data_mux;

	assign d_rd_any_hit = |d_rd_hit;
	assign d_wr_any_hit = |d_wr_hit;
	assign i_rd_any_hit = |i_rd_hit;

	assign dcache_rd_ready = !refilling && d_rd_any_hit;
	assign dcache_wr_ready = !refilling && d_wr_any_hit;
	assign icache_rd_ready = !refilling && i_rd_any_hit;

	assign d_rd_en = dcache_rdreq && dcache_rd_ready;
	assign d_wr_en = dcache_wrreq && dcache_wr_ready;
	assign i_rd_en = icache_rdreq && icache_rd_ready;

	for (genvar i = 0; i < `CACHE_NUM_LINES; i++) begin : g_line
		cache_line u_line (
			.clk(clk),
			.reset_n(reset_n),
			.d_rd_addr(dcache_rdaddr),
			.d_wr_addr(dcache_wraddr),
			.i_rd_addr(icache_rdaddr),
			.d_wr_data(dcache_in),
			.d_wr_en(d_wr_en),
			.d_rd_en(d_rd_en),
			.i_rd_en(i_rd_en),
			.fill(fill[i]),
			.fill_tag(fill_tag),
			.mem_out(mem_out),
			.mem_out_valid(mem_out_valid),
			.d_rd_hit(d_rd_hit[i]),
			.d_wr_hit(d_wr_hit[i]),
			.i_rd_hit(i_rd_hit[i]),
			.d_rd_data(d_rd_data[i]),
			.i_rd_data(i_rd_data[i]),
			.hitcnt(hitcnts[i]),
			.busy(line_busy[i]),
			.mem_addr(line_mem_addr[i]),
			.mem_data(line_mem_data[i]),
			.mem_wrreq(line_wrreq[i]),
			.mem_rdreq(line_rdreq[i])
		);
	end

	victim_select u_victim_select (
		.hitcnts(hitcnts),
		.victim(victim)
	);

	miss_control u_miss_control (
		.clk(clk),
		.reset_n(reset_n),
		.d_rd_req(dcache_rdreq),
		.d_wr_req(dcache_wrreq),
		.i_rd_req(icache_rdreq),
		.d_rd_addr(dcache_rdaddr),
		.d_wr_addr(dcache_wraddr),
		.i_rd_addr(icache_rdaddr),
		.d_rd_any_hit(d_rd_any_hit),
		.d_wr_any_hit(d_wr_any_hit),
		.i_rd_any_hit(i_rd_any_hit),
		.victim(victim),
		.line_busy(line_busy),
		.fill(fill),
		.fill_tag(fill_tag),
		.refilling(refilling)
	);

	// hit masks are one-hot, and only the refilling line talks to memory
	always_comb begin
		d_rd_mux = '0;
		i_rd_mux = '0;
		mem_addr_mux = '0;
		mem_data_mux = '0;
		for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
			if (d_rd_hit[i])
				d_rd_mux |= d_rd_data[i];
			if (i_rd_hit[i])
				i_rd_mux |= i_rd_data[i];
			if (line_wrreq[i] || line_rdreq[i]) begin
				mem_addr_mux.raw |= line_mem_addr[i].raw;
				mem_data_mux |= line_mem_data[i];
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			dcache_out_valid <= 1'b0;
			icache_out_valid <= 1'b0;
			mem_wrreq <= 1'b0;
			mem_rdreq <= 1'b0;
		end else begin
			dcache_out_valid <= d_rd_en;
			icache_out_valid <= i_rd_en;
			mem_wrreq <= |line_wrreq;
			mem_rdreq <= |line_rdreq;
		end
	end

	always_ff @(posedge clk) begin
		if (d_rd_en)
			dcache_out <= d_rd_mux;
		if (i_rd_en)
			icache_out <= i_rd_mux;
		if ((|line_wrreq) || (|line_rdreq)) begin
			mem_addr <= mem_addr_mux;
			mem_in <= mem_data_mux;
		end
	end

endmodule

`default_nettype wire

// File: hw/miss_control.sv
`default_nettype none

module miss_control (
	input wire clk,
	input wire reset_n,
	input wire d_rd_req,
	input wire d_wr_req,
	input wire i_rd_req,
	input wire cache_pkg::addr_t d_rd_addr,
	input wire cache_pkg::addr_t d_wr_addr,
	input wire cache_pkg::addr_t i_rd_addr,
	input wire d_rd_any_hit,
	input wire d_wr_any_hit,
	input wire i_rd_any_hit,
	input wire cache_pkg::line_mask_t victim,
	input wire cache_pkg::line_mask_t line_busy,
	output cache_pkg::line_mask_t fill,
	output cache_pkg::tag_t fill_tag,
	output logic refilling
);

	localparam logic [1:0] ST_NORMAL = 2'd0;
	localparam logic [1:0] ST_REQUEST_SENT = 2'd1;
	localparam logic [1:0] ST_WAIT_FOR_FINISH = 2'd2;

	logic [1:0] state;
	cache_pkg::line_mask_t victim_r;
	logic d_rd_miss;
	logic d_wr_miss;
	logic i_rd_miss;
	logic any_miss;
	logic victim_busy;

	assign d_rd_miss = d_rd_req && !d_rd_any_hit;
	assign d_wr_miss = d_wr_req && !d_wr_any_hit;
	assign i_rd_miss = i_rd_req && !i_rd_any_hit;
	assign any_miss = d_rd_miss || d_wr_miss || i_rd_miss;

	assign victim_busy = |(victim_r & line_busy);
	assign refilling = (state != ST_NORMAL);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= ST_NORMAL;
			fill <= '0;
			victim_r <= '0;
		end else begin
			fill <= '0;
			case (state)
				ST_NORMAL: begin
					if (any_miss) begin
						fill <= victim;
						victim_r <= victim;
						state <= ST_REQUEST_SENT;
					end
				end
				ST_REQUEST_SENT: begin
					// the line acknowledges by raising busy
					if (victim_busy)
						state <= ST_WAIT_FOR_FINISH;
				end
				ST_WAIT_FOR_FINISH: begin
					if (!victim_busy)
						state <= ST_NORMAL;
				end
				default: begin
					state <= ST_NORMAL;
				end
			endcase
		end
	end

	// data read wins over data write, which wins over instruction read
	always_ff @(posedge clk) begin
		if (state == ST_NORMAL) begin
			if (d_rd_miss)
				fill_tag <= d_rd_addr.fields.tag;
			else if (d_wr_miss)
				fill_tag <= d_wr_addr.fields.tag;
			else if (i_rd_miss)
				fill_tag <= i_rd_addr.fields.tag;
		end
	end

	a_fill_onehot0: assert property (@(posedge clk) disable iff (!reset_n)
		$onehot0(fill));

endmodule

`default_nettype wire

// File: hw/victim_select.sv
`include "cache_config.svh"
`default_nettype none

module victim_select (
	input wire cache_pkg::hitcnt_t hitcnts [`CACHE_NUM_LINES],
	output cache_pkg::line_mask_t victim
);

	cache_pkg::hitcnt_t best_cnt;

	// strict compare so that on a tie the lower index is kept
	always_comb begin
		best_cnt = hitcnts[0];
		victim = cache_pkg::line_mask_t'(1);
		for (int i = 1; i < `CACHE_NUM_LINES; i++) begin
			if (hitcnts[i] < best_cnt) begin
				best_cnt = hitcnts[i];
				victim = cache_pkg::line_mask_t'(1) << i;
			end
		end
	end

endmodule

`default_nettype wire

// File: cache_line/cache_line.sv
`include "cache_config.svh"
`default_nettype none

module cache_line (
	input wire clk,
	input wire reset_n,
	input wire cache_pkg::addr_t d_rd_addr,
	input wire cache_pkg::addr_t d_wr_addr,
	input wire cache_pkg::addr_t i_rd_addr,
	input wire cache_pkg::data_t d_wr_data,
	input wire d_wr_en,
	input wire d_rd_en,
	input wire i_rd_en,
	input wire fill,
	input wire cache_pkg::tag_t fill_tag,
	input wire cache_pkg::data_t mem_out,
	input wire mem_out_valid,
	output logic d_rd_hit,
	output logic d_wr_hit,
	output logic i_rd_hit,
	output cache_pkg::data_t d_rd_data,
	output cache_pkg::data_t i_rd_data,
	output cache_pkg::hitcnt_t hitcnt,
	output logic busy,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::data_t mem_data,
	output logic mem_wrreq,
	output logic mem_rdreq
);

	localparam logic [1:0] SEQ_IDLE = 2'd0;
	localparam logic [1:0] SEQ_WRITE_BACK = 2'd1;
	localparam logic [1:0] SEQ_READ_REQ = 2'd2;
	localparam logic [1:0] SEQ_READ_WAIT = 2'd3;
	localparam cache_pkg::word_idx_t LAST_WORD = cache_pkg::word_idx_t'(`CACHE_LINE_WORDS - 1);

	logic [1:0] seq_state;
	cache_pkg::word_idx_t seq_word;
	logic valid;
	logic dirty;
	cache_pkg::tag_t tag_r;
	cache_pkg::data_t words [`CACHE_LINE_WORDS];

	logic d_rd_acc;
	logic d_wr_acc;
	logic i_rd_acc;
	logic [1:0] hit_inc;
	logic [`CACHE_HIT_BITS:0] hit_sum;
	logic tag_load;

	assign d_rd_hit = valid && (d_rd_addr.fields.tag == tag_r);
	assign d_wr_hit = valid && (d_wr_addr.fields.tag == tag_r);
	assign i_rd_hit = valid && (i_rd_addr.fields.tag == tag_r);

	assign d_rd_data = words[d_rd_addr.fields.word_idx];
	assign i_rd_data = words[i_rd_addr.fields.word_idx];

	assign d_rd_acc = d_rd_en && d_rd_hit;
	assign d_wr_acc = d_wr_en && d_wr_hit;
	assign i_rd_acc = i_rd_en && i_rd_hit;

	// up to three ports can hit this line in one cycle
	assign hit_inc = {1'b0, d_rd_acc} + {1'b0, d_wr_acc} + {1'b0, i_rd_acc};
	assign hit_sum = {1'b0, hitcnt} + {{(`CACHE_HIT_BITS - 1){1'b0}}, hit_inc};

	// the old tag stays in place until the last write-back word has left
	assign tag_load = ((seq_state == SEQ_IDLE) && fill && !dirty) ||
		((seq_state == SEQ_WRITE_BACK) && (seq_word == LAST_WORD));

	always_comb begin
		mem_addr.fields.tag = tag_r;
		mem_addr.fields.word_idx = seq_word;
		mem_addr.fields.byte_off = '0;
	end

	assign mem_data = words[seq_word];
	assign mem_wrreq = (seq_state == SEQ_WRITE_BACK);
	assign mem_rdreq = (seq_state == SEQ_READ_REQ);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			seq_state <= SEQ_IDLE;
			seq_word <= '0;
			busy <= 1'b0;
			valid <= 1'b0;
			dirty <= 1'b0;
			hitcnt <= '0;
		end else begin
			if (hit_sum[`CACHE_HIT_BITS])
				hitcnt <= '1;
			else
				hitcnt <= hit_sum[`CACHE_HIT_BITS-1:0];
			if (d_wr_acc)
				dirty <= 1'b1;

			case (seq_state)
				SEQ_IDLE: begin
					if (fill) begin
						busy <= 1'b1;
						valid <= 1'b0;
						hitcnt <= '0;
						seq_word <= '0;
						seq_state <= dirty ? SEQ_WRITE_BACK : SEQ_READ_REQ;
					end
				end
				SEQ_WRITE_BACK: begin
					// one word per cycle, memory takes writes without a handshake
					seq_word <= seq_word + 1'b1;
					if (seq_word == LAST_WORD)
						seq_state <= SEQ_READ_REQ;
				end
				SEQ_READ_REQ: begin
					seq_state <= SEQ_READ_WAIT;
				end
				SEQ_READ_WAIT: begin
					if (mem_out_valid) begin
						seq_word <= seq_word + 1'b1;
						if (seq_word == LAST_WORD) begin
							seq_state <= SEQ_IDLE;
							busy <= 1'b0;
							valid <= 1'b1;
							dirty <= 1'b0;
						end else begin
							seq_state <= SEQ_READ_REQ;
						end
					end
				end
				default: begin
					seq_state <= SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (d_wr_acc)
			words[d_wr_addr.fields.word_idx] <= d_wr_data;
		if ((seq_state == SEQ_READ_WAIT) && mem_out_valid)
			words[seq_word] <= mem_out;
		if (tag_load)
			tag_r <= fill_tag;
	end

	// the controller must wait for this line to finish before it fills again
	a_fill_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
		!(fill && busy));

endmodule

`default_nettype wire

// File: common/cache_pkg.sv
`include "cache_config.svh"
`default_nettype none

package cache_pkg;

	localparam int BYTE_OFF_BITS = $clog2(`CACHE_DATA_BITS / 8);
	localparam int WORD_IDX_BITS = $clog2(`CACHE_LINE_WORDS);
	localparam int TAG_BITS = `CACHE_ADDR_BITS - WORD_IDX_BITS - BYTE_OFF_BITS;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [WORD_IDX_BITS-1:0] word_idx;
		logic [BYTE_OFF_BITS-1:0] byte_off;
	} addr_fields_t;

	// the same address word, either raw or split into its cache fields
	typedef union packed {
		logic [`CACHE_ADDR_BITS-1:0] raw;
		addr_fields_t fields;
	} addr_t;

	typedef logic [`CACHE_DATA_BITS-1:0] data_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [WORD_IDX_BITS-1:0] word_idx_t;
	typedef logic [`CACHE_HIT_BITS-1:0] hitcnt_t;
	typedef logic [`CACHE_NUM_LINES-1:0] line_mask_t;

endpackage

`default_nettype wire

// File: common/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`default_nettype none

// address and data word widths
`define CACHE_ADDR_BITS 32
`define CACHE_DATA_BITS 32

// eight lines of one four-word block each
`define CACHE_NUM_LINES 8
`define CACHE_LINE_WORDS 4

// width of the saturating hit counter in every line
`define CACHE_HIT_BITS 8

`default_nettype wire

`endif
